// ==== slot_bus_pkg.sv ====
/*
 * Slot-side definitions for the card glue logic.
 * Holds the Apple data bus width, the per-card response bundle,
 * the data-out source encoding and the push-button debounce timing.
 * Imported by the arbiter, the button block and the top level.
 */

package slot_bus_pkg;

    // Apple II data bus
    localparam int BUS_DATA_W = 8;

    // One card's answer to the current bus cycle
    typedef struct packed {
        logic                  rd_en;
        logic [BUS_DATA_W-1:0] data;
        logic                  irq_n;
    } card_resp_t;

    // Owner of the data-out path
    typedef enum logic [1:0] {
        SRC_BUS,
        SRC_SSC,
        SRC_SSP,
        SRC_MB
    } card_src_e;

    // Board uses 10000 samples, scaled down so simulation stays short
    localparam int BUTTON_DEBOUNCE_CYCLES = 16;

    // Must hold BUTTON_DEBOUNCE_CYCLES - 1
    localparam int BUTTON_CNT_W = 5;

endpackage

// ==== av_pkg.sv ====
/*
 * Audio and video definitions shared by the mixer, the dimmer and the top.
 * Card audio is unsigned and is widened by fixed shifts before summing
 * into signed 16-bit stereo samples for the HDMI audio path.
 */

package av_pkg;

    // Audio
    localparam int CARD_AUDIO_W  = 10;
    localparam int MIX_W         = 13;
    localparam int SAMPLE_W      = 16;
    localparam int SPEAKER_SHIFT = 12;
    localparam int CARD_SHIFT    = 3;

    typedef struct packed {
        logic signed [SAMPLE_W-1:0] left;
        logic signed [SAMPLE_W-1:0] right;
    } stereo_sample_t;

    // Video
    localparam int COLOR_W    = 8;
    localparam int SCREEN_Y_W = 10;

    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
    } rgb_t;

endpackage

// ==== card_response_arbiter.sv ====
/*
 * Grants the card's single data-out path to one of the three slot cards.
 * Fixed priority SSC, then SSP, then MB; with no reader the bus data is echoed.
 * Interrupts from all cards are wire-ANDed. Outputs are registered (1 cycle).
 */
`timescale 1ns/1ps

module card_response_arbiter import slot_bus_pkg::*; (
    input  logic                  clk_logic_w,
    input  logic                  rst_n_i,
    input  card_resp_t            ssc_resp_i,
    input  card_resp_t            ssp_resp_i,
    input  card_resp_t            mb_resp_i,
    input  logic [BUS_DATA_W-1:0] bus_data_i,
    output logic                  data_out_en_o,
    output logic [BUS_DATA_W-1:0] data_out_o,
    output logic                  irq_n_o
);

    card_src_e grant;
    logic      any_rd;
    logic      irq_n_all;

    assign any_rd    = ssc_resp_i.rd_en | ssp_resp_i.rd_en | mb_resp_i.rd_en;
    assign irq_n_all = ssc_resp_i.irq_n & ssp_resp_i.irq_n & mb_resp_i.irq_n;

    // Serial card wins, sound card last
    always_comb begin
        if (ssc_resp_i.rd_en) begin
            grant = SRC_SSC;
        end else if (ssp_resp_i.rd_en) begin
            grant = SRC_SSP;
        end else if (mb_resp_i.rd_en) begin
            grant = SRC_MB;
        end else begin
            grant = SRC_BUS;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (!rst_n_i) begin
            data_out_en_o <= 1'b0;
            data_out_o    <= '0;
            irq_n_o       <= 1'b1;
        end else begin
            data_out_en_o <= any_rd;
            irq_n_o       <= irq_n_all;
            case (grant)
                SRC_SSC: data_out_o <= ssc_resp_i.data;
                SRC_SSP: data_out_o <= ssp_resp_i.data;
                SRC_MB:  data_out_o <= mb_resp_i.data;
                default: data_out_o <= bus_data_i;
            endcase
        end
    end

    // Enable tracks the previous cycle's read requests
    a_en_follows_rd: assert property (@(posedge clk_logic_w) disable iff (!rst_n_i)
        $past(rst_n_i) |->
            (data_out_en_o == $past(ssc_resp_i.rd_en || ssp_resp_i.rd_en || mb_resp_i.rd_en)));

    // IRQ only asserted when some card asked for it
    a_irq_has_source: assert property (@(posedge clk_logic_w) disable iff (!rst_n_i)
        ($past(rst_n_i) && !irq_n_o) |->
            $past(!ssc_resp_i.irq_n || !ssp_resp_i.irq_n || !mb_resp_i.irq_n));

endmodule

// ==== audio_mixer.sv ====
/*
 * Mixes the speaker bit, the sprite card audio and the stereo sound card
 * into signed 16-bit left and right samples, registered once.
 * Sprite audio and the speaker go to both channels.
 */
`timescale 1ns/1ps

module audio_mixer import av_pkg::*; (
    input  logic                    clk_logic_w,
    input  logic                    rst_n_i,
    input  logic                    speaker_i,
    input  logic [CARD_AUDIO_W-1:0] ssp_audio_i,
    input  logic [CARD_AUDIO_W-1:0] mb_audio_l_i,
    input  logic [CARD_AUDIO_W-1:0] mb_audio_r_i,
    output stereo_sample_t          sample_o
);

    logic [MIX_W-1:0]    speaker_ext;
    logic [MIX_W-1:0]    ssp_ext;
    logic [MIX_W-1:0]    mb_l_ext;
    logic [MIX_W-1:0]    mb_r_ext;
    logic [SAMPLE_W-1:0] sum_l;
    logic [SAMPLE_W-1:0] sum_r;

    // Speaker toggles at a large fixed amplitude
    assign speaker_ext = MIX_W'(speaker_i) << SPEAKER_SHIFT;
    assign ssp_ext     = MIX_W'(ssp_audio_i) << CARD_SHIFT;
    assign mb_l_ext    = MIX_W'(mb_audio_l_i) << CARD_SHIFT;
    assign mb_r_ext    = MIX_W'(mb_audio_r_i) << CARD_SHIFT;

    // Three 13-bit terms never reach bit 15
    assign sum_l = SAMPLE_W'(speaker_ext) + SAMPLE_W'(ssp_ext) + SAMPLE_W'(mb_l_ext);
    assign sum_r = SAMPLE_W'(speaker_ext) + SAMPLE_W'(ssp_ext) + SAMPLE_W'(mb_r_ext);

    always_ff @(posedge clk_logic_w) begin
        if (!rst_n_i) begin
            sample_o <= '0;
        end else begin
            sample_o.left  <= $signed(sum_l);
            sample_o.right <= $signed(sum_r);
        end
    end

    // Samples stay in the positive half of the signed range
    a_no_sign: assert property (@(posedge clk_logic_w) disable iff (!rst_n_i)
        !sample_o.left[SAMPLE_W-1] && !sample_o.right[SAMPLE_W-1]);

endmodule

// ==== scanline_dimmer.sv ====
/*
 * CRT-style scanline effect on the RGB output.
 * On odd rows, with scanlines enabled, every channel is halved.
 * One register stage, pixel_o is zero after reset.
 */
`timescale 1ns/1ps

module scanline_dimmer import av_pkg::*; (
    input  logic                  clk_logic_w,
    input  logic                  rst_n_i,
    input  logic                  scanlines_i,
    input  logic [SCREEN_Y_W-1:0] screen_y_i,
    input  rgb_t                  pixel_i,
    output rgb_t                  pixel_o
);

    logic dim;
    rgb_t pixel_half;

    // Only row parity matters
    assign dim = scanlines_i & screen_y_i[0];

    assign pixel_half.r = pixel_i.r >> 1;
    assign pixel_half.g = pixel_i.g >> 1;
    assign pixel_half.b = pixel_i.b >> 1;

    always_ff @(posedge clk_logic_w) begin
        if (!rst_n_i) begin
            pixel_o <= '0;
        end else if (dim) begin
            pixel_o <= pixel_half;
        end else begin
            pixel_o <= pixel_i;
        end
    end

endmodule

// ==== overlay_button.sv ====
/*
 * Push-button toggle for the debug overlay enable.
 * The raw button is synchronized, debounced by a stability counter,
 * and each debounced press flips overlay_en_o one cycle later.
 */
`timescale 1ns/1ps

module overlay_button import slot_bus_pkg::*; (
    input  logic clk_logic_w,
    input  logic rst_n_i,
    input  logic button_i,
    output logic overlay_en_o
);

    logic [1:0]              sync_q;
    logic [BUTTON_CNT_W-1:0] cnt_q;
    logic                    level_q;
    logic                    level_prev_q;
    logic                    press;

    assign press = level_q & ~level_prev_q;

    always_ff @(posedge clk_logic_w) begin
        if (!rst_n_i) begin
            sync_q       <= '0;
            cnt_q        <= '0;
            level_q      <= 1'b0;
            level_prev_q <= 1'b0;
            overlay_en_o <= 1'b0;
        end else begin
            sync_q       <= {sync_q[0], button_i};
            level_prev_q <= level_q;

            // Count samples that disagree with the accepted level
            if (sync_q[1] == level_q) begin
                cnt_q <= '0;
            end else if (cnt_q == BUTTON_CNT_W'(BUTTON_DEBOUNCE_CYCLES - 1)) begin
                cnt_q   <= '0;
                level_q <= sync_q[1];
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end

            if (press) begin
                overlay_en_o <= ~overlay_en_o;
            end
        end
    end

    // Toggle only right after the debounced level rose
    a_toggle_on_press: assert property (@(posedge clk_logic_w) disable iff (!rst_n_i)
        ($past(rst_n_i) && $changed(overlay_en_o)) |-> ($past(level_q) && !$past(level_q, 2)));

endmodule

// ==== slot_card_hub.sv ====
/*
 * Top level of the card-side glue.
 * Connects the card response arbiter, the audio mixer, the scanline
 * dimmer and the overlay button to the card's outside ports.
 * No registers of its own, so each path keeps its block's latency.
 */
`timescale 1ns/1ps

module slot_card_hub import slot_bus_pkg::*, av_pkg::*; (
    input  logic                    clk_logic_w,
    input  logic                    rst_n_i,

    // Slot cards and Apple bus
    input  card_resp_t              ssc_resp_i,
    input  card_resp_t              ssp_resp_i,
    input  card_resp_t              mb_resp_i,
    input  logic [BUS_DATA_W-1:0]   bus_data_i,
    output logic                    data_out_en_o,
    output logic [BUS_DATA_W-1:0]   data_out_o,
    output logic                    irq_n_o,

    // Audio
    input  logic                    speaker_i,
    input  logic [CARD_AUDIO_W-1:0] ssp_audio_i,
    input  logic [CARD_AUDIO_W-1:0] mb_audio_l_i,
    input  logic [CARD_AUDIO_W-1:0] mb_audio_r_i,
    output stereo_sample_t          sample_o,

    // Video
    input  logic                    scanlines_i,
    input  logic [SCREEN_Y_W-1:0]   screen_y_i,
    input  rgb_t                    pixel_i,
    output rgb_t                    pixel_o,

    // Debug overlay button
    input  logic                    button_i,
    output logic                    overlay_en_o
);

    card_response_arbiter arbiter0 (
        .clk_logic_w   (clk_logic_w),
        .rst_n_i       (rst_n_i),
        .ssc_resp_i    (ssc_resp_i),
        .ssp_resp_i    (ssp_resp_i),
        .mb_resp_i     (mb_resp_i),
        .bus_data_i    (bus_data_i),
        .data_out_en_o (data_out_en_o),
        .data_out_o    (data_out_o),
        .irq_n_o       (irq_n_o)
    );

    audio_mixer mixer0 (
        .clk_logic_w  (clk_logic_w),
        .rst_n_i      (rst_n_i),
        .speaker_i    (speaker_i),
        .ssp_audio_i  (ssp_audio_i),
        .mb_audio_l_i (mb_audio_l_i),
        .mb_audio_r_i (mb_audio_r_i),
        .sample_o     (sample_o)
    );

    scanline_dimmer dimmer0 (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .scanlines_i (scanlines_i),
        .screen_y_i  (screen_y_i),
        .pixel_i     (pixel_i),
        .pixel_o     (pixel_o)
    );

    overlay_button button0 (
        .clk_logic_w  (clk_logic_w),
        .rst_n_i      (rst_n_i),
        .button_i     (button_i),
        .overlay_en_o (overlay_en_o)
    );

endmodule

// ==== tb_slot_card_hub.sv ====
/*
 * Self-checking testbench for the slot card hub.
 * A table of fixed and LCG rows drives the arbiter, mixer and dimmer paths,
 * then a button sequence exercises the overlay toggle.
 */
`timescale 1ns/1ps

module tb_slot_card_hub import slot_bus_pkg::*, av_pkg::*; ();

    localparam int CLK_PERIOD  = 100;
    localparam int NUM_FIXED   = 8;
    localparam int NUM_RAND    = 24;
    localparam int NUM_ROWS    = NUM_FIXED + NUM_RAND;
    localparam int HOLD_CYCLES = BUTTON_DEBOUNCE_CYCLES + 4;
    localparam int GLITCH_LEN  = BUTTON_DEBOUNCE_CYCLES / 2;
    localparam int BTN_SEQ_LEN = 4 * HOLD_CYCLES + GLITCH_LEN;
    localparam int WATCHDOG_CYCLES = NUM_ROWS + BTN_SEQ_LEN + 20;

    typedef struct packed {
        card_resp_t            ssc;
        card_resp_t            ssp;
        card_resp_t            mb;
        logic [BUS_DATA_W-1:0] bus_data;
        logic                  speaker;
        logic [9:0]            ssp_audio;
        logic [9:0]            mb_l;
        logic [9:0]            mb_r;
        logic                  scanlines;
        logic [9:0]            screen_y;
        rgb_t                  pixel;
        logic                  exp_en;
        logic [7:0]            exp_data;
        logic                  exp_irq_n;
        stereo_sample_t        exp_sample;
        rgb_t                  exp_pixel;
    } row_t;

    logic clk_logic_w;
    logic rst_n_i;
    card_resp_t ssc_resp_i, ssp_resp_i, mb_resp_i;
    logic [BUS_DATA_W-1:0] bus_data_i, data_out_o;
    logic data_out_en_o, irq_n_o;
    logic speaker_i;
    logic [CARD_AUDIO_W-1:0] ssp_audio_i, mb_audio_l_i, mb_audio_r_i;
    stereo_sample_t sample_o;
    logic scanlines_i;
    logic [SCREEN_Y_W-1:0] screen_y_i;
    rgb_t pixel_i, pixel_o;
    logic button_i, overlay_en_o;

    row_t        table_q [NUM_ROWS];
    logic [31:0] lcg_state;
    int          errors;

    slot_card_hub dut0 (.*);

    initial clk_logic_w = 1'b0;
    always #(CLK_PERIOD / 2) clk_logic_w = ~clk_logic_w;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Expected outputs straight from the arbitration, mixing and dimming rules
    function automatic row_t fill_expected(input row_t r);
        row_t e;
        int   left;
        int   right;
        e = r;
        e.exp_en = r.ssc.rd_en | r.ssp.rd_en | r.mb.rd_en;
        if (r.ssc.rd_en) e.exp_data = r.ssc.data;
        else if (r.ssp.rd_en) e.exp_data = r.ssp.data;
        else if (r.mb.rd_en) e.exp_data = r.mb.data;
        else e.exp_data = r.bus_data;
        e.exp_irq_n = r.ssc.irq_n & r.ssp.irq_n & r.mb.irq_n;
        left  = r.speaker * 4096 + r.ssp_audio * 8 + r.mb_l * 8;
        right = r.speaker * 4096 + r.ssp_audio * 8 + r.mb_r * 8;
        e.exp_sample.left  = left[15:0];
        e.exp_sample.right = right[15:0];
        if (r.scanlines && r.screen_y[0]) begin
            e.exp_pixel.r = r.pixel.r / 2;
            e.exp_pixel.g = r.pixel.g / 2;
            e.exp_pixel.b = r.pixel.b / 2;
        end else begin
            e.exp_pixel = r.pixel;
        end
        return e;
    endfunction

    // rd and irq bits ordered {ssc, ssp, mb}
    function automatic row_t make_row(input logic [2:0] rd, input logic [2:0] irq,
                                      input logic spk, input logic [9:0] ssp_a,
                                      input logic [9:0] l, input logic [9:0] r_a,
                                      input logic scan, input logic [9:0] y,
                                      input logic [23:0] pix);
        row_t r;
        r = '0;
        r.ssc = '{rd_en: rd[2], data: 8'hA1, irq_n: irq[2]};
        r.ssp = '{rd_en: rd[1], data: 8'hB2, irq_n: irq[1]};
        r.mb  = '{rd_en: rd[0], data: 8'hC3, irq_n: irq[0]};
        r.bus_data  = 8'h5E;
        r.speaker   = spk;
        r.ssp_audio = ssp_a;
        r.mb_l      = l;
        r.mb_r      = r_a;
        r.scanlines = scan;
        r.screen_y  = y;
        r.pixel     = pix;
        return fill_expected(r);
    endfunction

    task automatic random_row(output row_t r);
        logic [31:0] v [8];
        for (int k = 0; k < 8; k++) begin
            lcg_state = lcg_next(lcg_state);
            v[k] = lcg_state;
        end
        r = make_row(v[0][18:16], v[0][22:20], v[0][24], v[1][25:16], v[2][25:16],
                     v[3][25:16], v[4][16], v[5][25:16], {v[6][23:8], v[7][23:16]});
        r.ssc.data = v[4][31:24];
        r.ssp.data = v[5][31:24];
        r.mb.data  = v[6][31:24];
        r.bus_data = v[7][31:24];
        r = fill_expected(r);
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic apply_row(input row_t r);
        ssc_resp_i   = r.ssc;
        ssp_resp_i   = r.ssp;
        mb_resp_i    = r.mb;
        bus_data_i   = r.bus_data;
        speaker_i    = r.speaker;
        ssp_audio_i  = r.ssp_audio;
        mb_audio_l_i = r.mb_l;
        mb_audio_r_i = r.mb_r;
        scanlines_i  = r.scanlines;
        screen_y_i   = r.screen_y;
        pixel_i      = r.pixel;
    endtask

    task automatic check_row(input int i);
        row_t r;
        r = table_q[i];
        compare($sformatf("row %0d data_out_en", i), r.exp_en, data_out_en_o);
        compare($sformatf("row %0d data_out", i), r.exp_data, data_out_o);
        compare($sformatf("row %0d irq_n", i), r.exp_irq_n, irq_n_o);
        compare($sformatf("row %0d sample left", i), r.exp_sample.left, sample_o.left);
        compare($sformatf("row %0d sample right", i), r.exp_sample.right, sample_o.right);
        compare($sformatf("row %0d pixel", i), r.exp_pixel, pixel_o);
    endtask

    task automatic check_idle(input string name);
        compare({name, " data_out_en"}, 0, data_out_en_o);
        compare({name, " irq_n"}, 1, irq_n_o);
        compare({name, " sample"}, 0, sample_o);
        compare({name, " pixel"}, 0, pixel_o);
        compare({name, " overlay_en"}, 0, overlay_en_o);
    endtask

    task automatic button_step(input string name, input logic level, input int cycles,
                               input logic expected);
        button_i = level;
        repeat (cycles) @(negedge clk_logic_w);
        compare(name, expected, overlay_en_o);
    endtask

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        errors    = 0;
        lcg_state = 32'd21523;
        rst_n_i   = 1'b0;
        button_i  = 1'b0;
        apply_row(make_row(3'b000, 3'b111, 1'b0, 0, 0, 0, 1'b0, 0, 24'h0));
        bus_data_i = '0;

        table_q[0] = make_row(3'b000, 3'b111, 1'b0, 10'd0, 10'd0, 10'd0, 1'b0, 10'd0, 24'h0);
        table_q[1] = make_row(3'b001, 3'b110, 1'b1, 10'd0, 10'd0, 10'd0, 1'b0, 10'd1, 24'h102030);
        table_q[2] = make_row(3'b010, 3'b101, 1'b1, 10'd1023, 10'd1023, 10'd1023, 1'b0, 10'd4,
                              24'hFFFFFF);
        table_q[3] = make_row(3'b011, 3'b011, 1'b0, 10'd100, 10'd300, 10'd7, 1'b1, 10'd6,
                              24'h808080);
        table_q[4] = make_row(3'b100, 3'b000, 1'b0, 10'd5, 10'd0, 10'd1, 1'b1, 10'd3, 24'hFF8140);
        table_q[5] = make_row(3'b101, 3'b111, 1'b1, 10'd0, 10'd512, 10'd0, 1'b1, 10'd2,
                              24'hFF8140);
        table_q[6] = make_row(3'b110, 3'b100, 1'b0, 10'd1, 10'd2, 10'd3, 1'b0, 10'd5, 24'h7F3F01);
        table_q[7] = make_row(3'b111, 3'b111, 1'b0, 10'd9, 10'd9, 10'd9, 1'b1, 10'd1023,
                              24'h010203);
        for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
            random_row(table_q[i]);
        end

        // Reset held for 4 rising edges, outputs checked in between
        repeat (4) begin
            @(negedge clk_logic_w);
            check_idle("reset");
        end
        rst_n_i = 1'b1;
        @(negedge clk_logic_w);
        check_idle("after reset");

        // One row per cycle, each checked one cycle after it was applied
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(table_q[i]);
            @(negedge clk_logic_w);
            check_row(i);
        end

        button_step("button first press", 1'b1, HOLD_CYCLES, 1'b1);
        button_step("button release", 1'b0, HOLD_CYCLES, 1'b1);
        button_step("button second press", 1'b1, HOLD_CYCLES, 1'b0);
        button_step("button glitch low", 1'b0, GLITCH_LEN, 1'b0);
        button_step("button after glitch", 1'b1, HOLD_CYCLES, 1'b0);

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
slot_bus_pkg.sv
av_pkg.sv
card_response_arbiter.sv
audio_mixer.sv
scanline_dimmer.sv
overlay_button.sv
slot_card_hub.sv
tb_slot_card_hub.sv

// ==== Bender.yml ====
package:
  name: slot_card_hub

sources:
  - slot_bus_pkg.sv
  - av_pkg.sv
  - card_response_arbiter.sv
  - audio_mixer.sv
  - scanline_dimmer.sv
  - overlay_button.sv
  - slot_card_hub.sv
  - target: simulation
    files:
      - tb_slot_card_hub.sv
